// ==== project.f ====
src/switch_pkg.sv
src/port_arbiter.sv
src/frame_receiver.sv
src/frame_forwarder.sv
src/switch_arbiter.sv
verification/switch_arbiter_properties.sv
verification/switch_checker.sv
verification/tb_switch_arbiter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_switch_arbiter -o sim_switch_arbiter -f project.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_switch_arbiter > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== src/frame_forwarder.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_forwarder
(
  input  logic                             core_clock,
  input  logic                             clk1p,
  input  logic                             grant_active,
  input  switch_pkg::frame_t               frame,
  input  logic                             frame_loaded,
  output logic [switch_pkg::num_ports-1:0] dout,
  output logic                             frame_done
);

  import switch_pkg::*;

  logic [frame_bits-1:0] shift_reg;
  bit_count_t            out_count;
  logic                  sending;
  logic                  last_bit;
  port_index_t           decode_port;
  logic                  decode_hit;
  port_index_t           target_port;
  logic                  target_hit;
  logic [7:0]            offset_n;
  logic [7:0]            offset_p;

  // ########################################
  // Destination decode
  // ########################################

  always_comb
  begin
    offset_n    = frame.header.dest_addr - addr_n_base;
    offset_p    = frame.header.dest_addr - addr_p_base;
    decode_hit  = 1'b0;
    decode_port = '0;
    if (offset_p < 8'(addr_p_count))
    begin
      decode_hit  = 1'b1;
      decode_port = port_index_t'(offset_p);
    end
    else if (offset_n < 8'(addr_n_count))
    begin
      // n ports sit right after the p ports
      decode_hit  = 1'b1;
      decode_port = port_index_t'(addr_p_count) + port_index_t'(offset_n);
    end
  end

  // ########################################
  // Serial output
  // ########################################

  assign last_bit   = sending && (out_count == bit_count_t'(frame_bits - 1));
  assign frame_done = grant_active && last_bit;

  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      sending   <= 1'b0;
      out_count <= '0;
    end
    else if (!grant_active)
    begin
      sending   <= 1'b0;
      out_count <= '0;
    end
    else if (frame_loaded)
    begin
      sending   <= 1'b1;
      out_count <= '0;
    end
    else if (sending)
    begin
      if (last_bit)
      begin
        sending <= 1'b0;
      end
      out_count <= out_count + 1'b1;
    end
  end

  always_ff @(posedge core_clock)
  begin
    if (frame_loaded)
    begin
      shift_reg   <= frame.bits;
      target_port <= decode_port;
      target_hit  <= decode_hit;
    end
    else if (sending)
    begin
      shift_reg <= shift_reg << 1;
    end
  end

  // Unknown destination keeps every line quiet
  always_comb
  begin
    dout = '0;
    if (grant_active && sending && target_hit)
    begin
      dout[target_port] = shift_reg[frame_bits-1];
    end
  end

endmodule

`default_nettype wire

// ==== src/frame_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_receiver
(
  input  logic                             core_clock,
  input  logic                             clk1p,
  input  logic [switch_pkg::num_ports-1:0] din,
  input  logic                             grant_active,
  input  switch_pkg::port_index_t          grant_port,
  output switch_pkg::frame_t               frame,
  output logic                             frame_loaded
);

  import switch_pkg::*;

  bit_count_t bit_count;
  logic       capture;

  // First 80 granted cycles carry the header
  assign capture = grant_active && (bit_count < bit_count_t'(frame_bits));

  // Counts cycles of the current grant
  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      bit_count <= '0;
    end
    else if (!grant_active)
    begin
      bit_count <= '0;
    end
    else
    begin
      bit_count <= bit_count + 1'b1;
    end
  end

  // Deserializer, first bit ends up in the MSB
  always_ff @(posedge core_clock)
  begin
    if (capture)
    begin
      frame.bits <= {frame.bits[frame_bits-2:0], din[grant_port]};
    end
  end

  // Cycle 81 of the grant
  assign frame_loaded = grant_active && (bit_count == bit_count_t'(frame_bits));

endmodule

`default_nettype wire

// ==== src/port_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module port_arbiter
(
  input  logic                             core_clock,
  input  logic                             clk1p,
  input  logic [switch_pkg::num_ports-1:0] req,
  input  logic                             frame_done,
  output logic [switch_pkg::num_ports-1:0] gnt,
  output logic                             grant_active,
  output switch_pkg::port_index_t          grant_port
);

  import switch_pkg::*;

  logic                 pick_valid;
  port_index_t          pick_port;
  logic [num_ports-1:0] pick_onehot;
  logic                 release_grant;

  // Fixed priority, port 0 first
  always_comb
  begin
    pick_port = '0;
    for (int i = num_ports - 1; i >= 0; i--)
    begin
      if (req[i])
      begin
        pick_port = port_index_t'(i);
      end
    end
    pick_onehot = '0;
    pick_onehot[pick_port] = pick_valid;
  end

  assign pick_valid = |req;

  // End of frame or the requester gave up
  assign release_grant = frame_done || !req[grant_port];

  // ########################################
  // Grant FSM, idle is grant_active low
  // ########################################

  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      gnt          <= '0;
      grant_active <= 1'b0;
      grant_port   <= '0;
    end
    else if (grant_active)
    begin
      // Always back to idle for one cycle
      if (release_grant)
      begin
        gnt          <= '0;
        grant_active <= 1'b0;
      end
    end
    else if (pick_valid)
    begin
      gnt          <= pick_onehot;
      grant_active <= 1'b1;
      grant_port   <= pick_port;
    end
  end

endmodule

`default_nettype wire

// ==== src/switch_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module switch_arbiter
(
  input  logic                             core_clock,
  input  logic                             clk1p,
  input  logic [switch_pkg::num_ports-1:0] req,
  input  logic [switch_pkg::num_ports-1:0] din,
  output logic [switch_pkg::num_ports-1:0] gnt,
  output logic [switch_pkg::num_ports-1:0] dout
);

  import switch_pkg::*;

  logic        grant_active;
  port_index_t grant_port;
  frame_t      frame;
  logic        frame_loaded;
  logic        frame_done;

  // Grant ownership
  port_arbiter i_port_arbiter
  (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .req          (req),
    .frame_done   (frame_done),
    .gnt          (gnt),
    .grant_active (grant_active),
    .grant_port   (grant_port)
  );

  // Header capture from the granted port
  frame_receiver i_frame_receiver
  (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .din          (din),
    .grant_active (grant_active),
    .grant_port   (grant_port),
    .frame        (frame),
    .frame_loaded (frame_loaded)
  );

  // Replay toward the destination port
  frame_forwarder i_frame_forwarder
  (
    .core_clock   (core_clock),
    .clk1p        (clk1p),
    .grant_active (grant_active),
    .frame        (frame),
    .frame_loaded (frame_loaded),
    .dout         (dout),
    .frame_done   (frame_done)
  );

endmodule

`default_nettype wire

// ==== src/switch_pkg.sv ====
`default_nettype none

package switch_pkg;

  // ########################################
  // Sizes
  // ########################################

  localparam int num_ports  = 9;
  localparam int frame_bits = 80;

  // Port number, 0..4 are 1p..5p and 5..8 are 1n..4n
  typedef logic [3:0] port_index_t;

  // Cycles within one grant, 0..160
  typedef logic [7:0] bit_count_t;

  // ########################################
  // Header layout, MSB first on the wire
  // ########################################

  typedef struct packed {
    logic [7:0]  preamble;
    logic [7:0]  src_addr;
    logic [7:0]  dest_addr;
    logic [7:0]  clock_freq;
    logic [15:0] data_length;
    logic [15:0] data_size;
    logic [15:0] data_crc;
  } header_t;

  // Same 80 bits as fields or as a flat shift vector
  typedef union packed {
    header_t               header;
    logic [frame_bits-1:0] bits;
  } frame_t;

  // ########################################
  // Address map
  // ########################################

  // 0x00..0x03 reach the n ports
  localparam logic [7:0] addr_n_base  = 8'h00;
  localparam int         addr_n_count = 4;

  // 0xF0..0xF4 reach the p ports
  localparam logic [7:0] addr_p_base  = 8'hF0;
  localparam int         addr_p_count = 5;

endpackage

`default_nettype wire

// ==== verification/switch_arbiter_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module switch_arbiter_properties
(
  input logic                             core_clock,
  input logic                             clk1p,
  input logic [switch_pkg::num_ports-1:0] req,
  input logic [switch_pkg::num_ports-1:0] gnt
);

  localparam int max_grant_cycles = 161;

  int grant_cycles;

  // Length of the grant in progress
  always_ff @(posedge core_clock or posedge clk1p)
  begin
    if (clk1p)
    begin
      grant_cycles <= 0;
    end
    else if (gnt != '0)
    begin
      grant_cycles <= grant_cycles + 1;
    end
    else
    begin
      grant_cycles <= 0;
    end
  end

  a_gnt_onehot: assert property (@(posedge core_clock) disable iff (clk1p) $onehot0(gnt))
    else $error("gnt has more than one port set");

  a_gnt_has_req: assert property (@(posedge core_clock) disable iff (clk1p)
    (gnt & ~$past(req)) == '0)
    else $error("gnt high for a port whose req was low");

  // Counter holds the cycles already spent, so the last allowed one sees 160
  a_gnt_length: assert property (@(posedge core_clock) disable iff (clk1p)
    (gnt != '0) |-> (grant_cycles < max_grant_cycles))
    else $error("gnt stayed high longer than one frame");

endmodule

`default_nettype wire

// ==== verification/switch_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module switch_checker
(
  input  logic                             core_clock,
  input  logic [switch_pkg::num_ports-1:0] gnt,
  input  logic [switch_pkg::num_ports-1:0] dout,
  input  logic [switch_pkg::num_ports-1:0] exp_gnt,
  input  logic [switch_pkg::num_ports-1:0] exp_dout,
  input  logic [127:0]                     test_name,
  input  logic                             test_end,
  input  logic                             run_done,
  output int                               error_count,
  output int                               tests_failed
);

  int errors_total   = 0;
  int errors_in_test = 0;
  int passed         = 0;
  int failed         = 0;

  assign error_count  = errors_total;
  assign tests_failed = failed;

  // DUT outputs and model values are both settled at the falling edge
  always @(negedge core_clock)
  begin
    if (gnt !== exp_gnt)
    begin
      $display("[ERROR] %0s: gnt expected %b actual %b at %0t",
               test_name, exp_gnt, gnt, $time);
      errors_total   = errors_total + 1;
      errors_in_test = errors_in_test + 1;
    end
    if (dout !== exp_dout)
    begin
      $display("[ERROR] %0s: dout expected %b actual %b at %0t",
               test_name, exp_dout, dout, $time);
      errors_total   = errors_total + 1;
      errors_in_test = errors_in_test + 1;
    end
    if (test_end)
    begin
      if (errors_in_test == 0)
      begin
        passed = passed + 1;
        $display("test %0s: passed", test_name);
      end
      else
      begin
        failed = failed + 1;
        $display("test %0s: failed with %0d mismatches", test_name, errors_in_test);
      end
      errors_in_test = 0;
    end
    if (run_done)
    begin
      $display("tests passed %0d, tests failed %0d, mismatches %0d",
               passed, failed, errors_total);
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_switch_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_switch_arbiter;

  import switch_pkg::*;

  localparam int frame_cycles   = 161;
  localparam int timeout_cycles = 12 * 165 + 200;

  logic                 core_clock;
  logic                 clk1p;
  logic [num_ports-1:0] req;
  logic [num_ports-1:0] din;
  logic [num_ports-1:0] gnt;
  logic [num_ports-1:0] dout;
  logic [num_ports-1:0] exp_gnt;
  logic [num_ports-1:0] exp_dout;
  logic [num_ports-1:0] launch_mask;
  logic [127:0]         test_name;
  logic                 test_end;
  logic                 run_done;
  int                   error_count;
  int                   tests_failed;
  int                   cycle_count;
  integer               seed;

  // Per port header and progress, plus the reference model state
  frame_t hdr [num_ports];
  int     seen [num_ports];
  int     stop_at [num_ports];
  logic   m_active;
  int     m_port;
  int     m_count;

  switch_arbiter i_switch_arbiter
  (
    .core_clock (core_clock),
    .clk1p      (clk1p),
    .req        (req),
    .din        (din),
    .gnt        (gnt),
    .dout       (dout)
  );

  switch_checker i_switch_checker
  (
    .core_clock   (core_clock),
    .gnt          (gnt),
    .dout         (dout),
    .exp_gnt      (exp_gnt),
    .exp_dout     (exp_dout),
    .test_name    (test_name),
    .test_end     (test_end),
    .run_done     (run_done),
    .error_count  (error_count),
    .tests_failed (tests_failed)
  );

  bind port_arbiter switch_arbiter_properties i_switch_arbiter_properties
  (
    .core_clock (core_clock),
    .clk1p      (clk1p),
    .req        (req),
    .gnt        (gnt)
  );

  initial
  begin
    core_clock = 1'b0;
    forever #5 core_clock = ~core_clock;
  end

  // ########################################
  // Model helpers
  // ########################################

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % n;
  endfunction

  // 0xF0..0xF4 reach ports 0..4, 0x00..0x03 reach ports 5..8
  function automatic int port_of_addr(input logic [7:0] addr);
    if (addr >= 8'hF0 && addr <= 8'hF4)
    begin
      return int'(addr) - 240;
    end
    if (addr <= 8'h03)
    begin
      return int'(addr) + 5;
    end
    return -1;
  endfunction

  function automatic logic [7:0] addr_of(input int port);
    if (port < 5)
    begin
      return 8'hF0 + 8'(port);
    end
    return 8'(port - 5);
  endfunction

  function automatic int lowest_port(input logic [num_ports-1:0] mask);
    int found;
    found = -1;
    for (int i = 0; i < num_ports; i++)
    begin
      if (mask[i] && found < 0)
      begin
        found = i;
      end
    end
    return found;
  endfunction

  task automatic make_header(input int port, input logic [7:0] dest);
    logic [95:0] raw;
    raw = {$random(seed), $random(seed), $random(seed)};
    hdr[port].bits = raw[frame_bits-1:0];
    hdr[port].header.dest_addr = dest;
    stop_at[port] = frame_cycles;
  endtask

  // Expected gnt and dout for the cycle after this edge
  task automatic model_cycle();
    logic [num_ports-1:0] next_gnt;
    logic [num_ports-1:0] next_dout;
    int                   target;
    if (m_active)
    begin
      if (!req[m_port] || m_count == frame_cycles)
      begin
        m_active = 1'b0;
      end
      else
      begin
        m_count = m_count + 1;
      end
    end
    else if (req != '0)
    begin
      m_port   = lowest_port(req);
      m_active = 1'b1;
      m_count  = 1;
    end
    next_gnt  = '0;
    next_dout = '0;
    if (m_active)
    begin
      next_gnt[m_port] = 1'b1;
      target = port_of_addr(hdr[m_port].header.dest_addr);
      if (m_count > 81 && target >= 0)
      begin
        next_dout[target] = hdr[m_port].bits[frame_cycles - m_count];
      end
    end
    exp_gnt  <= next_gnt;
    exp_dout <= next_dout;
  endtask

  // ########################################
  // Port behavior and test flow
  // ########################################

  task automatic drive_ports();
    logic [num_ports-1:0] next_req;
    logic [num_ports-1:0] next_din;
    next_req = req;
    next_din = din;
    for (int p = 0; p < num_ports; p++)
    begin
      if (launch_mask[p])
      begin
        next_req[p] = 1'b1;
        next_din[p] = hdr[p].bits[frame_bits-1];
        seen[p]     = 0;
      end
      else if (req[p] && gnt[p])
      begin
        seen[p] = seen[p] + 1;
        next_din[p] = 1'b0;
        if (seen[p] >= stop_at[p])
        begin
          next_req[p] = 1'b0;
        end
        else if (seen[p] < frame_bits)
        begin
          next_din[p] = hdr[p].bits[frame_bits-1-seen[p]];
        end
      end
    end
    launch_mask = '0;
    req <= next_req;
    din <= next_din;
  endtask

  task automatic step();
    @(posedge core_clock);
    model_cycle();
    drive_ports();
  endtask

  task automatic finish_test();
    test_end <= 1'b1;
    step();
    test_end <= 1'b0;
  endtask

  // Requesters drop req on completion, so an empty req means all done
  task automatic run_frames(input logic [num_ports-1:0] mask);
    launch_mask = mask;
    step();
    do
    begin
      step();
    end
    while (req != '0);
    repeat (2) step();
    finish_test();
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge core_clock);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    logic [num_ports-1:0] mask;
    logic [7:0]           addr;
    int                   src;
    int                   dest_i;
    seed        = 12858;
    clk1p       = 1'b1;
    req         = '0;
    din         = '0;
    exp_gnt     = '0;
    exp_dout    = '0;
    launch_mask = '0;
    test_end    = 1'b0;
    run_done    = 1'b0;
    test_name   = '0;
    m_active    = 1'b0;
    m_port      = 0;
    m_count     = 0;
    for (int p = 0; p < num_ports; p++)
    begin
      hdr[p]     = '0;
      seen[p]    = 0;
      stop_at[p] = frame_cycles;
    end
    repeat (5) @(posedge core_clock);
    clk1p <= 1'b0;

    $sformat(test_name, "reset_state");
    repeat (3) step();
    finish_test();

    // Three ports at once, served in priority order
    $sformat(test_name, "priority");
    mask = '0;
    while ($countones(mask) < 3)
    begin
      mask[rand_below(num_ports)] = 1'b1;
    end
    dest_i = 0;
    for (int p = 0; p < num_ports; p++)
    begin
      if (mask[p])
      begin
        make_header(p, addr_of(dest_i));
        dest_i = dest_i + 1;
      end
    end
    run_frames(mask);

    // Remaining destinations one at a time
    for (int i = 3; i < num_ports; i++)
    begin
      src = rand_below(num_ports);
      make_header(src, addr_of(i));
      $sformat(test_name, "dest_%02h", addr_of(i));
      mask      = '0;
      mask[src] = 1'b1;
      run_frames(mask);
    end

    $sformat(test_name, "unmapped");
    do
    begin
      addr = 8'(rand_below(256));
    end
    while (port_of_addr(addr) >= 0);
    src = rand_below(num_ports);
    make_header(src, addr);
    mask      = '0;
    mask[src] = 1'b1;
    run_frames(mask);

    // Requester gives up while its header is being replayed
    $sformat(test_name, "abort");
    src = rand_below(num_ports);
    make_header(src, addr_of(rand_below(num_ports)));
    stop_at[src] = 85 + rand_below(70);
    mask      = '0;
    mask[src] = 1'b1;
    run_frames(mask);
    stop_at[src] = frame_cycles;

    run_done <= 1'b1;
    step();
    if (error_count == 0 && tests_failed == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
